// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_frame_writer
RTL_TOP   ?= frame_writer_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal
LINTFLAGS ?= --lint-only --timing

SRCS := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/burst_writer.sv ====
`default_nettype none

module burst_writer (
    input  logic                          aclk,
    input  logic                          rstn,
    input  logic                          burst_ready,
    input  frame_writer_pkg::pixel_word_t word,
    input  logic                          wready,
    input  logic                          awready,
    input  logic                          bvalid,
    input  frame_writer_pkg::axi_resp_t   bresp,
    output logic                          pop,
    output logic                          frame_start_pop,
    output logic                          wvalid,
    output logic                          wlast,
    output logic                          awvalid,
    output logic                          aw_accept,
    output logic                          bready,
    output logic                          write_err,
    output frame_writer_pkg::axi_data_t   wdata
);

    localparam int half  = frame_writer_pkg::half_width;
    localparam int cnt_w = $clog2(frame_writer_pkg::burst_beats);

    frame_writer_pkg::write_state_t state;

    logic [half-1:0]  hi_q;
    logic             hi_beat;
    logic [cnt_w-1:0] beat_cnt;
    logic             w_accept;
    logic             b_accept;

    assign w_accept  = wvalid & wready;
    assign b_accept  = bvalid & bready;
    assign aw_accept = awvalid & awready;

    assign awvalid = (state == frame_writer_pkg::addr);
    assign bready  = (state == frame_writer_pkg::resp);

    // next word only once both beats of the last one are gone
    assign pop             = (state == frame_writer_pkg::data) & ~wvalid;
    assign frame_start_pop = pop & word[0];

    assign wlast = (beat_cnt == cnt_w'(frame_writer_pkg::burst_beats - 1));

    always_ff @(posedge aclk) begin
        if (!rstn) begin
            state     <= frame_writer_pkg::idle;
            write_err <= 1'b0;
        end else begin
            write_err <= 1'b0;
            case (state)
                frame_writer_pkg::idle: begin
                    if (burst_ready) begin
                        state <= frame_writer_pkg::data;
                    end
                end
                frame_writer_pkg::data: begin
                    if (w_accept & wlast) begin
                        state <= frame_writer_pkg::addr;
                    end
                end
                frame_writer_pkg::addr: begin
                    if (aw_accept) begin
                        state <= frame_writer_pkg::resp;
                    end
                end
                frame_writer_pkg::resp: begin
                    if (b_accept) begin
                        // bad response is flagged, the burst is not retried
                        write_err <= (bresp != frame_writer_pkg::resp_okay);
                        state     <= frame_writer_pkg::idle;
                    end
                end
                default: begin
                    state <= frame_writer_pkg::idle;
                end
            endcase
        end
    end

    // beat packing
    always_ff @(posedge aclk) begin
        if (pop) begin
            wdata <= frame_writer_pkg::axi_data_t'({word[0], word[half:1]});
            hi_q  <= word[2*half:half+1];
        end else if (w_accept & ~hi_beat) begin
            wdata <= frame_writer_pkg::axi_data_t'(hi_q);
        end
    end

    always_ff @(posedge aclk) begin
        if (!rstn) begin
            wvalid  <= 1'b0;
            hi_beat <= 1'b0;
        end else if (pop) begin
            wvalid  <= 1'b1;
            hi_beat <= 1'b0;
        end else if (w_accept) begin
            if (hi_beat) begin
                wvalid <= 1'b0;
            end
            hi_beat <= 1'b1;
        end
    end

    // accepted beats in this burst
    always_ff @(posedge aclk) begin
        if (!rstn) begin
            beat_cnt <= '0;
        end else if (state != frame_writer_pkg::data) begin
            beat_cnt <= '0;
        end else if (w_accept) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/frame_buffer_addr.sv ====
`default_nettype none

module frame_buffer_addr #(
    parameter int addr_width = 32
) (
    input  logic                        aclk,
    input  logic                        rstn,
    input  logic                        frame_start_pop,
    input  logic                        aw_accept,
    output frame_writer_pkg::axi_addr_t awaddr
);

    localparam int idx_last = frame_writer_pkg::num_buffers - 1;

    frame_writer_pkg::buf_idx_t buf_idx;
    frame_writer_pkg::buf_idx_t next_idx;

    logic [addr_width-1:0] addr_q;
    logic [addr_width-1:0] next_base;

    // 0 -> 1 -> 2 -> 0
    assign next_idx = (buf_idx == frame_writer_pkg::buf_idx_t'(idx_last)) ?
                      '0 : buf_idx + 1'b1;

    // buffer index selects the bank
    assign next_base = addr_width'(next_idx) << frame_writer_pkg::bank_shift;

    assign awaddr = frame_writer_pkg::axi_addr_t'(addr_q);

    always_ff @(posedge aclk) begin
        if (!rstn) begin
            buf_idx <= '0;
            addr_q  <= '0;
        end else if (frame_start_pop) begin
            // new frame always moves to the next buffer
            buf_idx <= next_idx;
            addr_q  <= next_base;
        end else if (aw_accept) begin
            addr_q <= addr_q + addr_width'(frame_writer_pkg::burst_beats);
        end
    end

endmodule

`default_nettype wire

// ==== design/frame_writer_pkg.sv ====
`default_nettype none

package frame_writer_pkg;

    // input video bus
    localparam int pixel_width     = 24;
    localparam int pixels_per_word = 4;
    localparam int pixel_bus_width = pixel_width * pixels_per_word;
    // each word leaves as two beats of this many pixel bits
    localparam int half_width      = pixel_bus_width / 2;

    typedef logic [pixel_bus_width-1:0] pixel_bus_t;
    // tag in bit 0, pixels above it
    typedef logic [pixel_bus_width:0]   pixel_word_t;

    typedef logic [31:0] axi_addr_t;
    typedef logic [63:0] axi_data_t;
    typedef logic [1:0]  axi_resp_t;

    // burst shape, awlen is burst_beats - 1
    localparam int burst_beats     = 8;
    localparam int words_per_burst = 4;

    // triple buffering, one buffer per bank
    localparam int bank_shift  = 27;
    localparam int num_buffers = 3;

    typedef logic [1:0] buf_idx_t;

    localparam axi_resp_t resp_okay = 2'b00;

    // write channel order is data, then address, then response
    typedef enum logic [1:0] {
        idle,
        data,
        addr,
        resp
    } write_state_t;

endpackage

`default_nettype wire

// ==== design/frame_writer_top.sv ====
`default_nettype none

module frame_writer_top #(
    parameter int fifo_depth = 16,
    parameter int addr_width = 32
) (
    input  logic                         aclk,
    input  logic                         rstn,
    input  logic                         ivs,
    input  logic                         ide,
    input  frame_writer_pkg::pixel_bus_t pixels,
    output frame_writer_pkg::axi_addr_t  awaddr,
    output logic [3:0]                   awlen,
    output logic                         awvalid,
    input  logic                         awready,
    output frame_writer_pkg::axi_data_t  wdata,
    output logic                         wlast,
    output logic                         wvalid,
    input  logic                         wready,
    input  frame_writer_pkg::axi_resp_t  bresp,
    input  logic                         bvalid,
    output logic                         bready,
    output logic                         write_err,
    output logic                         overflow
);

    logic                          push;
    frame_writer_pkg::pixel_word_t push_word;
    logic                          pop;
    frame_writer_pkg::pixel_word_t fifo_dout;
    logic                          burst_ready;
    logic                          frame_start_pop;
    logic                          aw_accept;

    // fixed burst length
    assign awlen = 4'(frame_writer_pkg::burst_beats - 1);

    video_capture u_capture (
        .aclk   (aclk),
        .rstn   (rstn),
        .ivs    (ivs),
        .ide    (ide),
        .pixels (pixels),
        .push   (push),
        .word   (push_word)
    );

    pixel_fifo #(
        .depth (fifo_depth)
    ) u_fifo (
        .aclk        (aclk),
        .rstn        (rstn),
        .push        (push),
        .din         (push_word),
        .pop         (pop),
        .dout        (fifo_dout),
        .burst_ready (burst_ready),
        .overflow    (overflow)
    );

    burst_writer u_writer (
        .aclk            (aclk),
        .rstn            (rstn),
        .burst_ready     (burst_ready),
        .word            (fifo_dout),
        .wready          (wready),
        .awready         (awready),
        .bvalid          (bvalid),
        .bresp           (bresp),
        .pop             (pop),
        .frame_start_pop (frame_start_pop),
        .wvalid          (wvalid),
        .wlast           (wlast),
        .awvalid         (awvalid),
        .aw_accept       (aw_accept),
        .bready          (bready),
        .write_err       (write_err),
        .wdata           (wdata)
    );

    frame_buffer_addr #(
        .addr_width (addr_width)
    ) u_addr (
        .aclk            (aclk),
        .rstn            (rstn),
        .frame_start_pop (frame_start_pop),
        .aw_accept       (aw_accept),
        .awaddr          (awaddr)
    );

endmodule

`default_nettype wire

// ==== design/pixel_fifo.sv ====
`default_nettype none

module pixel_fifo #(
    parameter int depth = 16
) (
    input  logic                          aclk,
    input  logic                          rstn,
    input  logic                          push,
    input  frame_writer_pkg::pixel_word_t din,
    input  logic                          pop,
    output frame_writer_pkg::pixel_word_t dout,
    output logic                          burst_ready,
    output logic                          overflow
);

    localparam int ptr_w = $clog2(depth);

    frame_writer_pkg::pixel_word_t mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == (ptr_w + 1)'(depth));
    assign do_push = push & ~full;
    assign do_pop  = pop & (count != '0);

    // show-ahead read
    assign dout = mem[rd_ptr];

    // enough words for one full burst
    assign burst_ready = (count >= (ptr_w + 1)'(frame_writer_pkg::words_per_burst));

    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            // word lost while full
            overflow <= push & full;
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/video_capture.sv ====
`default_nettype none

module video_capture (
    input  logic                      aclk,
    input  logic                      rstn,
    input  logic                      ivs,
    input  logic                      ide,
    input  frame_writer_pkg::pixel_bus_t  pixels,
    output logic                      push,
    output frame_writer_pkg::pixel_word_t word
);

    logic ivs_d;
    logic ide_d;
    logic armed;
    logic frame_start;

    // first active word after a vsync edge
    assign frame_start = ide & ~ide_d & armed;

    assign push = ide;
    assign word = {pixels, frame_start};

    always_ff @(posedge aclk) begin
        if (!rstn) begin
            ivs_d <= 1'b0;
            ide_d <= 1'b0;
            armed <= 1'b0;
        end else begin
            ivs_d <= ivs;
            ide_d <= ide;
            if (ivs & ~ivs_d) begin
                armed <= 1'b1;
            end
            // tag only once per frame
            if (frame_start) begin
                armed <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
design/frame_writer_pkg.sv
design/video_capture.sv
design/pixel_fifo.sv
design/frame_buffer_addr.sv
design/burst_writer.sv
design/frame_writer_top.sv
tests/tb_frame_writer.sv

// ==== tests/tb_frame_writer.sv ====
`default_nettype none

module tb_frame_writer;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int fifo_depth = 16;
    localparam int tmo_cycles = 3000;

    logic                         aclk;
    logic                         rstn;
    logic                         ivs;
    logic                         ide;
    frame_writer_pkg::pixel_bus_t pixels;
    frame_writer_pkg::axi_addr_t  awaddr;
    logic [3:0]                   awlen;
    logic                         awvalid;
    logic                         awready;
    frame_writer_pkg::axi_data_t  wdata;
    logic                         wlast;
    logic                         wvalid;
    logic                         wready;
    frame_writer_pkg::axi_resp_t  bresp;
    logic                         bvalid;
    logic                         bready;
    logic                         write_err;
    logic                         overflow;

    // slave controls, set by the test sequence
    logic stall_en;
    logic aw_hold;
    int   err_bursts;

    // seen by the slave, cleared while in reset
    frame_writer_pkg::axi_data_t got_beats[$];
    logic                        got_last[$];
    frame_writer_pkg::axi_addr_t got_addr[$];
    int resp_count;
    int bad_resp_count;
    int err_pulses;
    int ovf_pulses;

    // reference model
    frame_writer_pkg::axi_data_t exp_beats[$];
    frame_writer_pkg::axi_addr_t exp_addr[$];
    int exp_idx;

    logic [31:0] lfsr_state;
    int errors;
    int test_errors;
    int tests_run;

    frame_writer_top #(
        .fifo_depth (fifo_depth),
        .addr_width (32)
    ) u_dut (
        .aclk      (aclk),
        .rstn      (rstn),
        .ivs       (ivs),
        .ide       (ide),
        .pixels    (pixels),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wlast     (wlast),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .write_err (write_err),
        .overflow  (overflow)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    // taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic frame_writer_pkg::pixel_bus_t random_pixels();
        frame_writer_pkg::pixel_bus_t v;
        for (int i = 0; i < $bits(v); i++) begin
            v[i] = lfsr_bit();
        end
        return v;
    endfunction

    // AXI write slave, ready and response driven on the falling edge
    initial begin
        wready  = 1'b0;
        awready = 1'b0;
        bvalid  = 1'b0;
        bresp   = frame_writer_pkg::resp_okay;
        forever begin
            @(negedge aclk);
            wready  = stall_en ? lfsr_bit() : 1'b1;
            awready = aw_hold ? 1'b0 : (stall_en ? lfsr_bit() : 1'b1);
            bvalid  = bready;
            bresp   = (bad_resp_count < err_bursts) ? 2'b10 : frame_writer_pkg::resp_okay;
        end
    end

    // handshake monitor
    initial begin
        forever begin
            @(posedge aclk);
            if (!rstn) begin
                got_beats.delete();
                got_last.delete();
                got_addr.delete();
                resp_count     = 0;
                bad_resp_count = 0;
                err_pulses     = 0;
                ovf_pulses     = 0;
            end else begin
                if (wvalid && wready) begin
                    got_beats.push_back(wdata);
                    got_last.push_back(wlast);
                end
                if (awvalid && awready) begin
                    got_addr.push_back(awaddr);
                end
                if (bvalid && bready) begin
                    resp_count++;
                    if (bresp != frame_writer_pkg::resp_okay) begin
                        bad_resp_count++;
                    end
                end
                if (write_err) begin
                    err_pulses++;
                end
                if (overflow) begin
                    ovf_pulses++;
                end
            end
        end
    end

    task automatic check_data(input string name, input frame_writer_pkg::axi_data_t exp,
                              input frame_writer_pkg::axi_data_t act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_addr(input string name, input frame_writer_pkg::axi_addr_t exp,
                              input frame_writer_pkg::axi_addr_t act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_len(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic reset_dut();
        rstn       = 1'b0;
        ivs        = 1'b0;
        ide        = 1'b0;
        stall_en   = 1'b0;
        aw_hold    = 1'b0;
        err_bursts = 0;
        exp_beats.delete();
        exp_addr.delete();
        exp_idx = 0;
        repeat (2) @(negedge aclk);
        rstn = 1'b1;
    endtask

    // vsync pulse, then n_words active words back to back
    task automatic send_frame(input int n_words);
        frame_writer_pkg::pixel_bus_t pix;
        frame_writer_pkg::axi_addr_t  base;
        @(negedge aclk);
        ivs = 1'b1;
        @(negedge aclk);
        ivs = 1'b0;
        exp_idx = (exp_idx + 1) % frame_writer_pkg::num_buffers;
        base = frame_writer_pkg::axi_addr_t'(exp_idx) << frame_writer_pkg::bank_shift;
        for (int i = 0; i < n_words; i++) begin
            @(negedge aclk);
            pix    = random_pixels();
            ide    = 1'b1;
            pixels = pix;
            // low half plus tag, then high half
            exp_beats.push_back({15'b0, (i == 0), pix[47:0]});
            exp_beats.push_back({16'b0, pix[95:48]});
            if (i % frame_writer_pkg::words_per_burst == 0) begin
                exp_addr.push_back(base + frame_writer_pkg::axi_addr_t'(
                    (i / frame_writer_pkg::words_per_burst) * frame_writer_pkg::burst_beats));
            end
        end
        @(negedge aclk);
        ide = 1'b0;
    endtask

    task automatic wait_done(input string name);
        int cycles;
        cycles = 0;
        while ((got_beats.size() < exp_beats.size() || resp_count < exp_addr.size())
               && cycles < tmo_cycles) begin
            @(negedge aclk);
            cycles++;
        end
        if (got_beats.size() < exp_beats.size() || resp_count < exp_addr.size()) begin
            $display("%s: the slave did not receive all bursts in time", name);
            test_errors++;
        end else begin
            // write_err follows the last response by one cycle
            repeat (2) @(negedge aclk);
        end
    endtask

    task automatic compare_results(input string name, input int exp_err);
        check_count({name, " beat count"}, exp_beats.size(), got_beats.size());
        check_count({name, " burst count"}, exp_addr.size(), got_addr.size());
        for (int i = 0; i < exp_beats.size() && i < got_beats.size(); i++) begin
            check_data($sformatf("%s beat %0d", name, i), exp_beats[i], got_beats[i]);
            check_bit($sformatf("%s wlast %0d", name, i), (i % 8) == 7, got_last[i]);
        end
        for (int i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
            check_addr($sformatf("%s awaddr %0d", name, i), exp_addr[i], got_addr[i]);
        end
        check_count({name, " write_err pulses"}, exp_err, err_pulses);
        check_count({name, " overflow pulses"}, 0, ovf_pulses);
    endtask

    task automatic finish_test(input string name);
        $display("test %s finished with %0d mismatches", name, test_errors);
        errors += test_errors;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic test_reset_outputs();
        reset_dut();
        check_bit("reset_outputs wvalid", 1'b0, wvalid);
        check_bit("reset_outputs awvalid", 1'b0, awvalid);
        check_bit("reset_outputs bready", 1'b0, bready);
        check_bit("reset_outputs write_err", 1'b0, write_err);
        check_bit("reset_outputs overflow", 1'b0, overflow);
        // eight-beat bursts
        check_len("reset_outputs awlen", 4'd7, awlen);
        finish_test("reset_outputs");
    endtask

    task automatic test_single_frame();
        reset_dut();
        send_frame(8);
        wait_done("single_frame");
        compare_results("single_frame", 0);
        finish_test("single_frame");
    endtask

    task automatic test_rotation();
        reset_dut();
        // buffers 1, 2, 0, 1
        for (int f = 0; f < 4; f++) begin
            send_frame(8 + 4 * (f % 2));
            wait_done("rotation");
        end
        compare_results("rotation", 0);
        finish_test("rotation");
    endtask

    task automatic test_random_stalls();
        reset_dut();
        stall_en = 1'b1;
        for (int f = 0; f < 3; f++) begin
            send_frame(8);
            wait_done("random_stalls");
        end
        stall_en = 1'b0;
        compare_results("random_stalls", 0);
        finish_test("random_stalls");
    endtask

    task automatic test_error_response();
        reset_dut();
        err_bursts = 1;
        send_frame(8);
        wait_done("error_response");
        compare_results("error_response", 1);
        finish_test("error_response");
    endtask

    task automatic test_overflow();
        reset_dut();
        aw_hold = 1'b1;
        send_frame(fifo_depth + 8);
        repeat (2) @(negedge aclk);
        // one burst leaves the FIFO, the rest fills it
        check_count("overflow pulses", 8 - frame_writer_pkg::words_per_burst, ovf_pulses);
        aw_hold = 1'b0;
        finish_test("overflow");
    endtask

    initial begin
        rstn        = 1'b0;
        ivs         = 1'b0;
        ide         = 1'b0;
        pixels      = '0;
        stall_en    = 1'b0;
        aw_hold     = 1'b0;
        err_bursts  = 0;
        lfsr_state  = 32'h6d9f_5943;
        errors      = 0;
        test_errors = 0;
        tests_run   = 0;

        test_reset_outputs();
        test_single_frame();
        test_rotation();
        test_random_stalls();
        test_error_response();
        test_overflow();

        $display("%0d tests run, %0d mismatches", tests_run, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
